/* Makefile */
# Verilator build for the load/store unit testbench

VERILATOR  ?= verilator
TOP        := lsu_tb
FILELIST   := all.f
OBJ_DIR    := obj_dir
COMMON     := --timing --assert -Wno-fatal --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS := --lint-only
SIM_FLAGS  := --binary -j 0 --Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

# static checks on RTL and testbench
lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON)

# build and run, exit status follows the testbench
sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+tests
logic/lsu_pkg.sv
logic/axi_pkg.sv
logic/store_align.sv
logic/load_extract.sv
logic/lsu_ctrl.sv
logic/axil_data_ram.sv
logic/lsu_top.sv
tests/lsu_tb.sv

/* logic/axi_pkg.sv */
// AXI-lite channel payloads and response codes

package axi_pkg;

  // response codes as on the bus
  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } resp_e;

  // ==========================================================================
  // write side
  // ==========================================================================

  typedef lsu_pkg::addr_t aw_t;

  typedef struct packed {
    lsu_pkg::xdata_t data;
    lsu_pkg::strb_t  strb;
  } w_t;

  typedef struct packed {
    resp_e resp;
  } b_t;

  // ==========================================================================
  // read side
  // ==========================================================================

  typedef lsu_pkg::addr_t ar_t;

  typedef struct packed {
    lsu_pkg::xdata_t data;
    resp_e           resp;
  } r_t;

endpackage

/* logic/axil_data_ram.sv */
// AXI-lite data memory: strobed writes, range check, read and write response latencies

`timescale 1ns/1ps

module axil_data_ram #(
  parameter int MEM_WORDS = 256,
  parameter int RD_LAT    = 2,
  parameter int WR_LAT    = 1
) (
  input  logic         clk,
  input  logic         rst,
  input  logic         aw_valid_i,
  input  axi_pkg::aw_t aw_i,
  output logic         aw_ready_o,
  input  logic         w_valid_i,
  input  axi_pkg::w_t  w_i,
  output logic         w_ready_o,
  output logic         b_valid_o,
  output axi_pkg::b_t  b_o,
  input  logic         b_ready_i,
  input  logic         ar_valid_i,
  input  axi_pkg::ar_t ar_i,
  output logic         ar_ready_o,
  output logic         r_valid_o,
  output axi_pkg::r_t  r_o,
  input  logic         r_ready_i
);

  localparam int IDX_W = $clog2(MEM_WORDS);
  localparam int WCW   = $clog2(WR_LAT + 1) + 1;
  localparam int RCW   = $clog2(RD_LAT + 1) + 1;
  localparam lsu_pkg::addr_t ADDR_LIMIT = lsu_pkg::addr_t'(MEM_WORDS * 8);

  lsu_pkg::xdata_t mem [MEM_WORDS];

  logic             wr_hs, rd_hs;
  logic             aw_in_range, ar_in_range;
  logic [IDX_W-1:0] aw_idx, ar_idx;
  logic             wr_pend_q, rd_pend_q;
  logic [WCW-1:0]   wr_cnt_q;
  logic [RCW-1:0]   rd_cnt_q;
  axi_pkg::resp_e   b_resp_q, r_resp_q;
  lsu_pkg::xdata_t  r_data_q;

  assign aw_in_range = aw_i < ADDR_LIMIT;
  assign ar_in_range = ar_i < ADDR_LIMIT;
  assign aw_idx      = aw_i[IDX_W+2:3];
  assign ar_idx      = ar_i[IDX_W+2:3];

  // ==========================================================================
  // write side
  // ==========================================================================

  // address and data are taken together, one response at a time
  assign wr_hs      = aw_valid_i && w_valid_i && !wr_pend_q;
  assign aw_ready_o = wr_hs;
  assign w_ready_o  = wr_hs;

  always_ff @(posedge clk) begin
    if (wr_hs && aw_in_range) begin
      for (int i = 0; i < 8; i++) begin
        if (w_i.strb[i]) mem[aw_idx][i*8 +: 8] <= w_i.data[i*8 +: 8];
      end
    end
  end

  // counter loaded with WR_LAT, response shows once it reaches zero
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_pend_q <= 1'b0;
      wr_cnt_q  <= '0;
    end else if (wr_hs) begin
      wr_pend_q <= 1'b1;
      wr_cnt_q  <= WCW'(WR_LAT);
    end else if (b_valid_o && b_ready_i) begin
      wr_pend_q <= 1'b0;
    end else if (wr_pend_q && (wr_cnt_q != '0)) begin
      wr_cnt_q <= wr_cnt_q - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_hs) b_resp_q <= aw_in_range ? axi_pkg::OKAY : axi_pkg::SLVERR;
  end

  assign b_valid_o = wr_pend_q && (wr_cnt_q == '0);
  assign b_o       = '{resp: b_resp_q};

  // ==========================================================================
  // read side
  // ==========================================================================

  assign ar_ready_o = !rd_pend_q;
  assign rd_hs      = ar_valid_i && ar_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_pend_q <= 1'b0;
      rd_cnt_q  <= '0;
    end else if (rd_hs) begin
      rd_pend_q <= 1'b1;
      rd_cnt_q  <= RCW'(RD_LAT);
    end else if (r_valid_o && r_ready_i) begin
      rd_pend_q <= 1'b0;
    end else if (rd_pend_q && (rd_cnt_q != '0)) begin
      rd_cnt_q <= rd_cnt_q - 1'b1;
    end
  end

  // out of range reads return zero
  always_ff @(posedge clk) begin
    if (rd_hs) begin
      r_data_q <= ar_in_range ? mem[ar_idx] : '0;
      r_resp_q <= ar_in_range ? axi_pkg::OKAY : axi_pkg::SLVERR;
    end
  end

  assign r_valid_o = rd_pend_q && (rd_cnt_q == '0);
  assign r_o       = '{data: r_data_q, resp: r_resp_q};

endmodule

/* logic/load_extract.sv */
// load extractor: picks the addressed bytes of a read word and sign- or zero-extends them

`timescale 1ns/1ps

module load_extract (
  input  lsu_pkg::addr_lo_t addr_lo_i,
  input  lsu_pkg::width_e   width_i,
  input  logic              unsigned_i,
  input  lsu_pkg::xdata_t   rdata_i,
  output lsu_pkg::xdata_t   data_o
);

  lsu_pkg::xdata_t shifted;

  // addressed byte lands in lane 0
  assign shifted = rdata_i >> {addr_lo_i, 3'b000};

  always_comb begin
    case (width_i)
      lsu_pkg::BYTE: begin
        if (unsigned_i) begin
          data_o = {56'b0, shifted[7:0]};
        end else begin
          data_o = {{56{shifted[7]}}, shifted[7:0]};
        end
      end
      lsu_pkg::HALF: begin
        if (unsigned_i) begin
          data_o = {48'b0, shifted[15:0]};
        end else begin
          data_o = {{48{shifted[15]}}, shifted[15:0]};
        end
      end
      lsu_pkg::WORD: begin
        if (unsigned_i) begin
          data_o = {32'b0, shifted[31:0]};
        end else begin
          data_o = {{32{shifted[31]}}, shifted[31:0]};
        end
      end
      // full word, nothing to extend
      default: data_o = shifted;
    endcase
  end

endmodule

/* logic/lsu_ctrl.sv */
// load/store control: write and read channel FSMs, request latch, completion pulses

`timescale 1ns/1ps

module lsu_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                req_valid_i,
  input  lsu_pkg::lsu_req_t   req_i,
  input  axi_pkg::w_t         store_w_i,
  input  lsu_pkg::xdata_t     load_data_i,
  output lsu_pkg::load_sel_t  load_sel_o,
  output logic                aw_valid_o,
  output axi_pkg::aw_t        aw_o,
  input  logic                aw_ready_i,
  output logic                w_valid_o,
  output axi_pkg::w_t         w_o,
  input  logic                w_ready_i,
  input  logic                b_valid_i,
  input  axi_pkg::b_t         b_i,
  output logic                b_ready_o,
  output logic                ar_valid_o,
  output axi_pkg::ar_t        ar_o,
  input  logic                ar_ready_i,
  input  logic                r_valid_i,
  input  axi_pkg::r_t         r_i,
  output logic                r_ready_o,
  output logic                busy_o,
  output logic                wb_valid_o,
  output lsu_pkg::wb_t        wb_o,
  output logic                store_done_o,
  output logic                access_err_o
);

  typedef enum logic [1:0] {WS_IDLE, WS_ADDR_DATA, WS_RESP} wstate_e;
  typedef enum logic [1:0] {RS_IDLE, RS_ADDR, RS_DATA} rstate_e;

  wstate_e            wstate_q, wstate_d;
  rstate_e            rstate_q, rstate_d;
  logic               accept, accept_st, accept_ld;
  logic               aw_valid_q, w_valid_q, ar_valid_q;
  logic               aw_done, w_done, b_hs, r_hs;
  lsu_pkg::addr_t     addr_q;
  axi_pkg::w_t        w_q;
  lsu_pkg::reg_idx_t  rd_q;
  lsu_pkg::load_sel_t sel_q;
  logic [2:0]         align_mask;

  assign accept    = req_valid_i && !busy_o;
  assign accept_st = accept && req_i.is_store;
  assign accept_ld = accept && !req_i.is_store;

  // aw and w finish on their own, a channel already sent counts as done
  assign aw_done = !aw_valid_q || aw_ready_i;
  assign w_done  = !w_valid_q || w_ready_i;
  assign b_hs    = b_valid_i && b_ready_o;
  assign r_hs    = r_valid_i && r_ready_o;

  // ==========================================================================
  // write channel FSM
  // ==========================================================================

  always_comb begin
    wstate_d = wstate_q;
    case (wstate_q)
      WS_IDLE:      if (accept_st) wstate_d = WS_ADDR_DATA;
      WS_ADDR_DATA: if (aw_done && w_done) wstate_d = WS_RESP;
      WS_RESP:      if (b_hs) wstate_d = WS_IDLE;
      default:      wstate_d = WS_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wstate_q   <= WS_IDLE;
      aw_valid_q <= 1'b0;
      w_valid_q  <= 1'b0;
    end else begin
      wstate_q <= wstate_d;
      if (accept_st) begin
        aw_valid_q <= 1'b1;
        w_valid_q  <= 1'b1;
      end else begin
        if (aw_ready_i) aw_valid_q <= 1'b0;
        if (w_ready_i) w_valid_q <= 1'b0;
      end
    end
  end

  // ==========================================================================
  // read channel FSM
  // ==========================================================================

  always_comb begin
    rstate_d = rstate_q;
    case (rstate_q)
      RS_IDLE: if (accept_ld) rstate_d = RS_ADDR;
      RS_ADDR: if (ar_valid_q && ar_ready_i) rstate_d = RS_DATA;
      RS_DATA: if (r_hs) rstate_d = RS_IDLE;
      default: rstate_d = RS_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rstate_q   <= RS_IDLE;
      ar_valid_q <= 1'b0;
    end else begin
      rstate_q <= rstate_d;
      if (accept_ld) begin
        ar_valid_q <= 1'b1;
      end else if (ar_ready_i) begin
        ar_valid_q <= 1'b0;
      end
    end
  end

  // request payload, only taken while both FSMs are idle
  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= req_i.addr;
      w_q    <= store_w_i;
      rd_q   <= req_i.rd;
      sel_q  <= '{addr_lo: req_i.addr[2:0], width: req_i.width,
                  is_unsigned: req_i.is_unsigned};
    end
  end

  assign aw_valid_o = aw_valid_q;
  assign aw_o       = addr_q;
  assign w_valid_o  = w_valid_q;
  assign w_o        = w_q;
  assign b_ready_o  = (wstate_q == WS_RESP);
  assign ar_valid_o = ar_valid_q;
  assign ar_o       = addr_q;
  assign r_ready_o  = (rstate_q == RS_DATA);
  assign load_sel_o = sel_q;

  // completion, an error response replaces the normal pulse
  assign busy_o       = (wstate_q != WS_IDLE) || (rstate_q != RS_IDLE);
  assign store_done_o = b_hs && (b_i.resp == axi_pkg::OKAY);
  assign wb_valid_o   = r_hs && (r_i.resp == axi_pkg::OKAY);
  assign access_err_o = (b_hs && (b_i.resp != axi_pkg::OKAY)) ||
                        (r_hs && (r_i.resp != axi_pkg::OKAY));
  assign wb_o         = '{rd: rd_q, data: load_data_i};

  // ==========================================================================
  // checks
  // ==========================================================================

  // offset bits that must be zero for each size
  always_comb begin
    case (req_i.width)
      lsu_pkg::BYTE: align_mask = 3'b000;
      lsu_pkg::HALF: align_mask = 3'b001;
      lsu_pkg::WORD: align_mask = 3'b011;
      default:       align_mask = 3'b111;
    endcase
  end

  a_no_req_busy: assert property (@(posedge clk) disable iff (rst)
    req_valid_i |-> !busy_o)
    else $error("lsu_ctrl: request strobed while busy");

  a_aligned: assert property (@(posedge clk) disable iff (rst)
    req_valid_i |-> (req_i.addr[2:0] & align_mask) == 3'b000)
    else $error("lsu_ctrl: misaligned request");

  a_aw_stable: assert property (@(posedge clk) disable iff (rst)
    aw_valid_o && !aw_ready_i |=> aw_valid_o && $stable(aw_o))
    else $error("lsu_ctrl: aw dropped or changed before handshake");

  a_w_stable: assert property (@(posedge clk) disable iff (rst)
    w_valid_o && !w_ready_i |=> w_valid_o && $stable(w_o))
    else $error("lsu_ctrl: w dropped or changed before handshake");

  a_ar_stable: assert property (@(posedge clk) disable iff (rst)
    ar_valid_o && !ar_ready_i |=> ar_valid_o && $stable(ar_o))
    else $error("lsu_ctrl: ar dropped or changed before handshake");

endmodule

/* logic/lsu_pkg.sv */
// load/store unit types: data, address, strobe, register index, width code, request, write-back

package lsu_pkg;

  // widths that carry a meaning
  typedef logic [63:0] xdata_t;
  typedef logic [31:0] addr_t;
  typedef logic [7:0]  strb_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [2:0]  addr_lo_t;

  // access size of a load or store
  typedef enum logic [1:0] {
    BYTE  = 2'b00,
    HALF  = 2'b01,
    WORD  = 2'b10,
    DWORD = 2'b11
  } width_e;

  // one request from the execute stage
  typedef struct packed {
    logic     is_store;
    width_e   width;
    logic     is_unsigned;
    addr_t    addr;
    xdata_t   wdata;
    reg_idx_t rd;
  } lsu_req_t;

  // request fields needed to pick the load result out of a read word
  typedef struct packed {
    addr_lo_t addr_lo;
    width_e   width;
    logic     is_unsigned;
  } load_sel_t;

  // register write-back
  typedef struct packed {
    reg_idx_t rd;
    xdata_t   data;
  } wb_t;

endpackage

/* logic/lsu_top.sv */
// load/store unit top: control, store and load aligners, AXI-lite data memory

`timescale 1ns/1ps

module lsu_top #(
  parameter int MEM_WORDS = 256,
  parameter int RD_LAT    = 2,
  parameter int WR_LAT    = 1
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  output logic              busy_o,
  output logic              wb_valid_o,
  output lsu_pkg::wb_t      wb_o,
  output logic              store_done_o,
  output logic              access_err_o
);

  // AXI-lite channels between control and memory
  logic         aw_valid, aw_ready, w_valid, w_ready, b_valid, b_ready;
  logic         ar_valid, ar_ready, r_valid, r_ready;
  axi_pkg::aw_t aw;
  axi_pkg::w_t  w;
  axi_pkg::b_t  b;
  axi_pkg::ar_t ar;
  axi_pkg::r_t  r;

  // aligner hookup
  axi_pkg::w_t        store_w;
  lsu_pkg::load_sel_t load_sel;
  lsu_pkg::xdata_t    load_data;

  lsu_ctrl ctrl_inst (
    .clk, .rst, .req_valid_i, .req_i,
    .store_w_i(store_w), .load_data_i(load_data), .load_sel_o(load_sel),
    .aw_valid_o(aw_valid), .aw_o(aw), .aw_ready_i(aw_ready),
    .w_valid_o(w_valid), .w_o(w), .w_ready_i(w_ready),
    .b_valid_i(b_valid), .b_i(b), .b_ready_o(b_ready),
    .ar_valid_o(ar_valid), .ar_o(ar), .ar_ready_i(ar_ready),
    .r_valid_i(r_valid), .r_i(r), .r_ready_o(r_ready),
    .busy_o, .wb_valid_o, .wb_o, .store_done_o, .access_err_o
  );

  store_align store_align_inst (
    .addr_lo_i(req_i.addr[2:0]), .width_i(req_i.width),
    .wdata_i(req_i.wdata), .w_o(store_w)
  );

  load_extract load_extract_inst (
    .addr_lo_i(load_sel.addr_lo), .width_i(load_sel.width),
    .unsigned_i(load_sel.is_unsigned), .rdata_i(r.data), .data_o(load_data)
  );

  axil_data_ram #(
    .MEM_WORDS(MEM_WORDS), .RD_LAT(RD_LAT), .WR_LAT(WR_LAT)
  ) ram_inst (
    .clk, .rst,
    .aw_valid_i(aw_valid), .aw_i(aw), .aw_ready_o(aw_ready),
    .w_valid_i(w_valid), .w_i(w), .w_ready_o(w_ready),
    .b_valid_o(b_valid), .b_o(b), .b_ready_i(b_ready),
    .ar_valid_i(ar_valid), .ar_i(ar), .ar_ready_o(ar_ready),
    .r_valid_o(r_valid), .r_o(r), .r_ready_i(r_ready)
  );

endmodule

/* logic/store_align.sv */
// store aligner: moves store data into its byte lanes and builds the write strobe

`timescale 1ns/1ps

module store_align (
  input  lsu_pkg::addr_lo_t addr_lo_i,
  input  lsu_pkg::width_e   width_i,
  input  lsu_pkg::xdata_t   wdata_i,
  output axi_pkg::w_t       w_o
);

  lsu_pkg::strb_t  base_strb;
  lsu_pkg::strb_t  strb;
  lsu_pkg::xdata_t shifted;

  // lanes covered before the offset is applied
  always_comb begin
    case (width_i)
      lsu_pkg::BYTE: base_strb = 8'h01;
      lsu_pkg::HALF: base_strb = 8'h03;
      lsu_pkg::WORD: base_strb = 8'h0f;
      default:       base_strb = 8'hff;
    endcase
  end

  assign strb    = base_strb << addr_lo_i;
  assign shifted = wdata_i << {addr_lo_i, 3'b000};

  // lanes outside the strobe are driven as zero
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      w_o.data[i*8 +: 8] = strb[i] ? shifted[i*8 +: 8] : 8'h00;
    end
    w_o.strb = strb;
  end

endmodule

/* tests/lsu_ref_model.svh */
// reference model: byte mirror of the data memory, range rule, expected load values

`ifndef LSU_REF_MODEL_SVH
`define LSU_REF_MODEL_SVH

  // little-endian byte image, one entry per byte address
  logic [7:0] mirror [MEM_WORDS*8];

  function automatic bit addr_in_range(input lsu_pkg::addr_t addr);
    return addr < lsu_pkg::addr_t'(MEM_WORDS * 8);
  endfunction

  function automatic int access_bytes(input lsu_pkg::width_e width);
    case (width)
      lsu_pkg::BYTE: return 1;
      lsu_pkg::HALF: return 2;
      lsu_pkg::WORD: return 4;
      default:       return 8;
    endcase
  endfunction

  // stores beyond the range leave every byte as it was
  function automatic void mirror_store(input lsu_pkg::addr_t addr,
                                       input lsu_pkg::width_e width,
                                       input lsu_pkg::xdata_t wdata);
    if (addr_in_range(addr)) begin
      for (int i = 0; i < access_bytes(width); i++) begin
        mirror[addr + i] = wdata[i*8 +: 8];
      end
    end
  endfunction

  // gather the accessed bytes, then extend from the top accessed bit
  function automatic lsu_pkg::xdata_t mirror_load(input lsu_pkg::addr_t addr,
                                                  input lsu_pkg::width_e width,
                                                  input logic is_unsigned);
    lsu_pkg::xdata_t value;
    int              n;
    logic            sign;
    value = '0;
    n = access_bytes(width);
    for (int i = 0; i < n; i++) begin
      value[i*8 +: 8] = mirror[addr + i];
    end
    sign = is_unsigned ? 1'b0 : value[n*8 - 1];
    for (int i = n * 8; i < 64; i++) begin
      value[i] = sign;
    end
    return value;
  endfunction

`endif

/* tests/lsu_tb.sv */
// testbench for the load/store unit: clock, reset, directed and random accesses, timeout

`timescale 1ns/1ps

module lsu_tb;

  localparam int MEM_WORDS  = 256;
  localparam int NUM_RANDOM = 500;
  // sixteen cycles per operation plus some slack
  localparam int MAX_CYCLES = NUM_RANDOM * 16 + 100;

  logic              clk;
  logic              rst;
  logic              req_valid;
  lsu_pkg::lsu_req_t req;
  logic              busy;
  logic              wb_valid;
  lsu_pkg::wb_t      wb;
  logic              store_done;
  logic              access_err;
  logic [31:0]       lcg_state;
  int                cycles;

  `include "lsu_ref_model.svh"

  lsu_top #(.MEM_WORDS(MEM_WORDS), .RD_LAT(2), .WR_LAT(1)) lsu_top_inst (
    .clk, .rst, .req_valid_i(req_valid), .req_i(req), .busy_o(busy),
    .wb_valid_o(wb_valid), .wb_o(wb), .store_done_o(store_done),
    .access_err_o(access_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ==========================================================================
  // helpers
  // ==========================================================================

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic stop_run();
    $display("Testbench failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("error: time %0t signal %s expected %h actual %h",
               $time, name, expected, actual);
      stop_run();
    end
  endtask

  // one request, then wait for its completion pulse
  task automatic do_access(input logic is_store, input lsu_pkg::width_e width,
                           input logic is_unsigned, input lsu_pkg::addr_t addr,
                           input lsu_pkg::xdata_t wdata, input lsu_pkg::reg_idx_t rd);
    logic exp_err;
    int   waited;
    exp_err = !addr_in_range(addr);
    @(posedge clk);
    #1;
    check_value("busy_o", 1'b0, busy);
    req = '{is_store: is_store, width: width, is_unsigned: is_unsigned,
            addr: addr, wdata: wdata, rd: rd};
    req_valid = 1'b1;
    @(posedge clk);
    #1;
    req_valid = 1'b0;
    check_value("busy_o", 1'b1, busy);
    waited = 0;
    @(negedge clk);
    while (!(store_done || wb_valid || access_err)) begin
      waited++;
      if (waited > 16) begin
        $display("no completion pulse for the request at address %h", addr);
        stop_run();
      end
      @(negedge clk);
    end
    check_value("access_err_o", exp_err, access_err);
    check_value("store_done_o", is_store && !exp_err, store_done);
    check_value("wb_valid_o", !is_store && !exp_err, wb_valid);
    if (!is_store && !exp_err) begin
      check_value("wb_o.rd", rd, wb.rd);
      check_value("wb_o.data", mirror_load(addr, width, is_unsigned), wb.data);
    end
    if (is_store) begin
      mirror_store(addr, width, wdata);
    end
  endtask

  // aligned address, about one in sixteen placed past the memory
  // fields come from the upper bits, the low LCG bits repeat too soon
  function automatic lsu_pkg::addr_t random_addr(input lsu_pkg::width_e width);
    logic [31:0]    r;
    logic [2:0]     offset;
    lsu_pkg::addr_t base;
    r = next_rand();
    offset = r[31:29] & ~3'(access_bytes(width) - 1);
    base = lsu_pkg::addr_t'((r[24:9] % MEM_WORDS) * 8);
    if (r[28:25] == 4'h0) begin
      base = base + lsu_pkg::addr_t'(MEM_WORDS * 8);
    end
    return base + lsu_pkg::addr_t'(offset);
  endfunction

  task automatic random_access();
    logic [31:0]     r;
    lsu_pkg::width_e width;
    lsu_pkg::xdata_t data;
    r = next_rand();
    width = lsu_pkg::width_e'(r[31:30]);
    data = {next_rand(), next_rand()};
    do_access(r[29], width, r[28], random_addr(width), data,
              lsu_pkg::reg_idx_t'(r[27:23]));
  endtask

  // ==========================================================================
  // run limit
  // ==========================================================================

  initial begin
    cycles = 0;
    while (cycles <= MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("run exceeded %0d cycles without finishing", MAX_CYCLES);
    stop_run();
  end

  // ==========================================================================
  // test sequence
  // ==========================================================================

  initial begin
    lsu_pkg::width_e width;
    lsu_pkg::addr_t  addr;
    lcg_state = 32'h7eab_1c2d;
    rst = 1'b1;
    req_valid = 1'b0;
    req = '0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    // quiet outputs while nothing is requested
    repeat (4) begin
      @(negedge clk);
      check_value("busy_o", 1'b0, busy);
      check_value("wb_valid_o", 1'b0, wb_valid);
      check_value("store_done_o", 1'b0, store_done);
      check_value("access_err_o", 1'b0, access_err);
    end
    // fill every word so no load sees unwritten lanes
    for (int i = 0; i < MEM_WORDS; i++) begin
      do_access(1'b1, lsu_pkg::DWORD, 1'b0, lsu_pkg::addr_t'(i * 8),
                {next_rand(), next_rand()}, 5'd0);
    end
    // each width at the top of its word, read back signed, unsigned and whole
    for (int w = 0; w < 4; w++) begin
      width = lsu_pkg::width_e'(w);
      addr = lsu_pkg::addr_t'(32'h100 + w * 8 + 8 - (1 << w));
      do_access(1'b1, width, 1'b0, addr, 64'h0123_4567_89ab_cdef, 5'd0);
      do_access(1'b0, width, 1'b0, addr, '0, lsu_pkg::reg_idx_t'(w * 2 + 1));
      do_access(1'b0, width, 1'b1, addr, '0, lsu_pkg::reg_idx_t'(w * 2 + 2));
      do_access(1'b0, lsu_pkg::DWORD, 1'b0, addr & ~32'h7, '0,
                lsu_pkg::reg_idx_t'(w + 20));
    end
    // out of range store, its in-range alias must keep its contents
    do_access(1'b1, lsu_pkg::WORD, 1'b0, lsu_pkg::addr_t'(MEM_WORDS * 8 + 'h10),
              64'hdead_beef_dead_beef, 5'd0);
    do_access(1'b0, lsu_pkg::DWORD, 1'b0, 32'h10, '0, 5'd7);
    do_access(1'b0, lsu_pkg::HALF, 1'b0, lsu_pkg::addr_t'(MEM_WORDS * 8 + 'h22),
              '0, 5'd8);
    for (int n = 0; n < NUM_RANDOM; n++) begin
      random_access();
    end
    $display("Testbench passed");
    $finish;
  end

endmodule
